// File: vlog.f
+incdir+common
common/cpu_pkg.sv
common/bus_pkg.sv
design/priority_encoder.sv
design/machine_timer.sv
design/csr/csr_decode.sv
design/csr/csr_file.sv
design/csr_subsys.sv
sim/tb_csr_subsys.sv

// File: Makefile
VERILATOR	?= verilator
VFLAGS		= --binary --timing
TOP			= tb_csr_subsys
FILELIST	= vlog.f
OBJ_DIR		= obj_dir
LOG			= sim.log
PASS_MSG	= Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Pass message not found in $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim/tb_csr_subsys.sv
`default_nettype none

`include "csr_cfg.svh"

module tb_csr_subsys;

	import cpu_pkg::*;
	import bus_pkg::*;

	localparam int			WB_TIMEOUT		= 20;		// Cycles to wait for an ack
	localparam int			IRQ_TIMEOUT		= 200;		// NOPs to wait for the timer
	localparam logic [2:0]	F3_RW			= 3'd1;
	localparam logic [2:0]	F3_RS			= 3'd2;
	localparam logic [2:0]	F3_RC			= 3'd3;
	localparam logic [2:0]	F3_RWI			= 3'd5;
	localparam xlen_t		INST_NOP		= 32'h0000_0013;	// addi x0, x0, 0
	localparam xlen_t		INST_ECALL		= 32'h0000_0073;
	localparam xlen_t		INST_MRET		= 32'h3020_0073;
	localparam csr_addr_t	CSR_UNMAPPED	= 12'h7C0;		// Custom space that is not decoded

	logic			clk;
	logic			reset;
	retire_in_t		retire_in;
	logic			ready;
	logic	[15:0]	ext_irq;
	logic			meip;
	wb_req_t		wb_req;
	wb_rsp_t		wb_rsp;
	retire_out_t	result;
	logic			m_ena;
	logic			f_ena;
	logic	[2:0]	fpu_rm;

	retire_out_t	res;				// Result sampled before the edge
	xlen_t			model [0:4095];		// Expected CSR values by address
	xlen_t			pc_now;				// PC of the next retire
	integer			seed;
	int				errors;
	int				checks;
	int				tests;

	csr_subsys u_dut (
		.clk	(clk),
		.reset	(reset),
		.retire	(retire_in),
		.ready	(ready),
		.ext_irq	(ext_irq),
		.meip	(meip),
		.wb_req	(wb_req),
		.wb_rsp	(wb_rsp),
		.result	(result),
		.m_ena	(m_ena),
		.f_ena	(f_ena),
		.fpu_rm	(fpu_rm)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;				// 20 unit period

	function automatic xlen_t csr_inst(input logic [2:0] f3, input csr_addr_t addr,
									   input logic [4:0] rs1f, input logic [4:0] rd);
		return {addr, rs1f, f3, rd, 7'b1110011};
	endfunction

	// Set and clear rules of the Zicsr ops
	function automatic xlen_t apply_rmw(input logic [1:0] op, input xlen_t old_val,
										input xlen_t src);
		case (op)
		2'd2:		return old_val | src;
		2'd3:		return old_val & ~src;
		default:	return src;
		endcase
	endfunction

	function automatic xlen_t trap_status(input xlen_t ms);
		xlen_t r;
		r		= ms;
		r[7]	= ms[3];				// MIE into MPIE
		r[3]	= 1'b0;
		return r;
	endfunction

	function automatic xlen_t mret_status(input xlen_t ms);
		xlen_t r;
		r		= ms;
		r[3]	= ms[7];				// MPIE back into MIE
		r[7]	= 1'b1;
		return r;
	endfunction

	task automatic expect_eq(input xlen_t actual, input xlen_t expected, input string msg);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("CHECK FAILED at time %0t: %s: got 0x%08h, expected 0x%08h",
					 $time, msg, actual, expected);
		end
	endtask

	task automatic report_test(input string name, input int errs0);
		tests++;
		if (errors == errs0)
			$display("[%0t] %s: passed", $time, name);
		else
			$display("[%0t] %s: failed with %0d errors", $time, name, errors - errs0);
	endtask

	// Starts at posedge + 2, samples at negedge, ends at next posedge + 2
	task automatic retire_step(input xlen_t inst, input xlen_t rs1_val, input logic rdy);
		retire_in.valid		= 1'b1;
		retire_in.inst		= inst;
		retire_in.pc		= pc_now;
		retire_in.rs1_val	= rs1_val;
		ready				= rdy;
		@(negedge clk);
		res = result;
		@(posedge clk);
		#2;
		retire_in.valid	= 1'b0;
		ready			= 1'b1;
		pc_now			= pc_now + 32'd4;
	endtask

	task automatic wb_access(input logic we, input wb_addr_t adr, input logic [31:0] dat,
							 input logic [3:0] sel, output logic [31:0] rdat);
		int cycles;
		wb_req.cyc	= 1'b1;
		wb_req.stb	= 1'b1;
		wb_req.we	= we;
		wb_req.adr	= adr;
		wb_req.dat	= dat;
		wb_req.sel	= sel;
		cycles		= 0;
		while (!wb_rsp.ack && cycles < WB_TIMEOUT) begin
			@(posedge clk);
			#2;
			cycles++;
		end
		if (!wb_rsp.ack) begin
			$display("ERROR at time %0t: no Wishbone ack for register %0d", $time, adr);
			errors++;
		end else begin
			expect_eq(32'(cycles), 32'd1, "ack one cycle after stb");
		end
		rdat	= wb_rsp.dat;
		wb_req	= '0;
		@(posedge clk);					// Idle cycle lets ack drop
		#2;
	endtask

	task automatic csr_read(input csr_addr_t addr, output xlen_t val);
		retire_step(csr_inst(F3_RS, addr, 5'd0, 5'd1), '0, 1'b1);
		expect_eq(32'(res.trap_taken), 32'd0, $sformatf("trap on read of 0x%03h", addr));
		expect_eq(32'(res.rd_we), 32'd1, $sformatf("rd_we on read of 0x%03h", addr));
		val = res.rd_wdata;
	endtask

	task automatic csr_verify(input csr_addr_t addr);
		xlen_t val;
		csr_read(addr, val);
		expect_eq(val, model[addr], $sformatf("CSR 0x%03h value", addr));
	endtask

	// Legal CSR access that is checked and mirrored into the model
	task automatic csr_exec(input logic [2:0] f3, input csr_addr_t addr,
							input logic [4:0] rs1f, input logic [4:0] rd, input xlen_t rs1_val);
		xlen_t	src;
		xlen_t	old_val;
		logic	do_wr;
		logic	do_rd;
		src		= f3[2] ? {27'd0, rs1f} : rs1_val;	// zimm forms
		do_wr	= (f3[1:0] == 2'd1) || (rs1f != 5'd0);
		do_rd	= (f3[1:0] != 2'd1) || (rd != 5'd0);
		old_val	= model[addr];
		retire_step(csr_inst(f3, addr, rs1f, rd), rs1_val, 1'b1);
		expect_eq(32'(res.trap_taken), 32'd0, $sformatf("trap on op %0d at 0x%03h", f3, addr));
		expect_eq(32'(res.rd_we), 32'(do_rd), $sformatf("rd_we of op %0d", f3));
		if (do_rd)
			expect_eq(res.rd_wdata, old_val, $sformatf("old value by op %0d", f3));
		if (do_wr)
			model[addr] = apply_rmw(f3[1:0], old_val, src);
	endtask

	task automatic check_reset_values();
		int errs0;
		errs0 = errors;
		expect_eq(32'(wb_rsp.ack), 32'd0, "ack after reset");
		expect_eq(32'(result.trap_taken), 32'd0, "trap_taken after reset");
		expect_eq(32'(result.rd_we), 32'd0, "rd_we after reset");
		expect_eq(32'({m_ena, f_ena}), 32'd3, "M and F enabled");
		csr_verify(CSR_ADDR_MISA);		// 0x40001120
		csr_verify(CSR_ADDR_MSTATUS);	// 0x3800
		csr_verify(CSR_ADDR_MIE);
		csr_verify(CSR_ADDR_MCAUSE);
		report_test("reset_state", errs0);
	endtask

	task automatic exercise_csr_ops();
		int				errs0;
		int				r;
		int				k;
		logic	[2:0]	f3;
		logic	[4:0]	rs1f;
		xlen_t			data;
		errs0 = errors;
		for (r = 0; r < 3; r++) begin
			for (k = 0; k < 6; k++) begin
				f3		= (k < 3) ? 3'(k + 1) : 3'(k + 2);	// RW RS RC RWI RSI RCI
				data	= $random(seed);
				rs1f	= f3[2] ? data[4:0] : 5'd2;
				csr_exec(f3, CSR_ADDR_MSCRATCH, rs1f, 5'd1, data);
				csr_verify(CSR_ADDR_MSCRATCH);
			end
		end
		data = $random(seed);
		csr_exec(F3_RW, CSR_ADDR_MSCRATCH, 5'd2, 5'd0, data);	// rd is x0 so rd stays unwritten
		csr_verify(CSR_ADDR_MSCRATCH);
		csr_exec(F3_RWI, CSR_ADDR_MSCRATCH, 5'd17, 5'd0, '0);
		csr_verify(CSR_ADDR_MSCRATCH);
		csr_exec(F3_RWI, CSR_ADDR_FRM, 5'd3, 5'd0, '0);		// Round up
		expect_eq(32'(fpu_rm), 32'd3, "fpu_rm after frm write");
		model[CSR_ADDR_MSTATUS] = model[CSR_ADDR_MSTATUS] | 32'h8000_6000;	// FS dirty sets SD
		csr_verify(CSR_ADDR_MSTATUS);
		report_test("csr_ops", errs0);
	endtask

	task automatic illegal_trap(input xlen_t inst, input xlen_t rs1_val, input string what);
		xlen_t trap_pc;
		xlen_t val;
		trap_pc = pc_now;
		retire_step(inst, rs1_val, 1'b1);
		expect_eq(32'(res.trap_taken), 32'd1, {what, ": trap_taken"});
		expect_eq(32'(res.exc_taken), 32'd1, {what, ": exc_taken"});
		expect_eq(32'(res.int_taken), 32'd0, {what, ": int_taken"});
		expect_eq(32'(res.rd_we), 32'd0, {what, ": rd_we"});
		expect_eq(res.trap_addr, {model[CSR_ADDR_MTVEC][31:2], 2'b00}, {what, ": trap_addr"});
		model[CSR_ADDR_MSTATUS] = trap_status(model[CSR_ADDR_MSTATUS]);
		csr_read(CSR_ADDR_MEPC, val);
		expect_eq(val, trap_pc, {what, ": mepc"});
		csr_read(CSR_ADDR_MCAUSE, val);
		expect_eq(val, 32'd2, {what, ": mcause"});
	endtask

	task automatic provoke_illegal_access();
		int errs0;
		errs0 = errors;
		csr_exec(F3_RW, CSR_ADDR_MTVEC, 5'd1, 5'd0, 32'h0000_0100);	// Direct mode at base 0x100
		illegal_trap(csr_inst(F3_RS, CSR_UNMAPPED, 5'd0, 5'd1), '0, "unmapped read");
		illegal_trap(csr_inst(F3_RW, CSR_ADDR_MVENDORID, 5'd1, 5'd0), 32'h1234,
					 "mvendorid write");
		csr_exec(F3_RC, CSR_ADDR_MISA, 5'd1, 5'd0, 32'h0000_0020);	// Drop F
		model[CSR_ADDR_MSTATUS] = model[CSR_ADDR_MSTATUS] & ~32'h8000_6000;	// FS off clears SD
		expect_eq(32'(f_ena), 32'd0, "f_ena after misa clear");
		csr_verify(CSR_ADDR_MISA);
		illegal_trap(csr_inst(F3_RS, CSR_ADDR_FCSR, 5'd0, 5'd1), '0, "fcsr with F off");
		csr_verify(CSR_ADDR_MSTATUS);
		report_test("illegal_access", errs0);
	endtask

	task automatic ecall_mret_sequence();
		int		errs0;
		xlen_t	ecall_pc;
		xlen_t	val;
		errs0 = errors;
		csr_exec(F3_RS, CSR_ADDR_MSTATUS, 5'd1, 5'd0, 32'h0000_0008);	// MIE on
		csr_verify(CSR_ADDR_MSTATUS);
		// Stalled retires show a result but change nothing
		retire_step(INST_ECALL, '0, 1'b0);
		expect_eq(32'(res.trap_taken), 32'd1, "stalled ECALL still flags a trap");
		retire_step(csr_inst(F3_RW, CSR_ADDR_MSCRATCH, 5'd3, 5'd0), ~model[CSR_ADDR_MSCRATCH],
					1'b0);
		csr_verify(CSR_ADDR_MSCRATCH);
		csr_verify(CSR_ADDR_MSTATUS);
		csr_verify(CSR_ADDR_MTVEC);
		csr_read(CSR_ADDR_MCAUSE, val);
		expect_eq(val, 32'd2, "mcause unchanged by stall");
		ecall_pc = pc_now;
		retire_step(INST_ECALL, '0, 1'b1);
		expect_eq(32'(res.exc_taken), 32'd1, "ECALL exc_taken");
		expect_eq(res.trap_addr, {model[CSR_ADDR_MTVEC][31:2], 2'b00}, "ECALL trap_addr");
		model[CSR_ADDR_MSTATUS] = trap_status(model[CSR_ADDR_MSTATUS]);
		csr_read(CSR_ADDR_MCAUSE, val);
		expect_eq(val, 32'd11, "ECALL mcause");
		csr_read(CSR_ADDR_MEPC, val);
		expect_eq(val, ecall_pc, "ECALL mepc");
		csr_verify(CSR_ADDR_MSTATUS);		// MPIE set and MIE clear
		retire_step(INST_MRET, '0, 1'b1);
		expect_eq(32'(res.trap_taken), 32'd0, "MRET does not trap");
		expect_eq(res.ret_addr, ecall_pc, "MRET ret_addr");
		model[CSR_ADDR_MSTATUS] = mret_status(model[CSR_ADDR_MSTATUS]);
		csr_verify(CSR_ADDR_MSTATUS);
		report_test("ecall_mret", errs0);
	endtask

	task automatic timer_interrupt_flow();
		int		errs0;
		int		waited;
		logic	got;
		xlen_t	t_lo;
		xlen_t	dummy;
		xlen_t	irq_pc;
		xlen_t	val;
		errs0 = errors;
		csr_exec(F3_RW, CSR_ADDR_MTVEC, 5'd1, 5'd0, 32'h0000_0201);	// Vectored mode at base 0x200
		csr_exec(F3_RS, CSR_ADDR_MIE, 5'd1, 5'd0, 32'h0000_0080);		// MTIE
		csr_exec(F3_RS, CSR_ADDR_MSTATUS, 5'd1, 5'd0, 32'h0000_0008);	// MIE
		wb_access(1'b0, `TIMER_REG_MTIME_LO, '0, 4'hF, t_lo);
		wb_access(1'b1, `TIMER_REG_MTIMECMP_LO, t_lo + 32'd40, 4'hF, dummy);
		wb_access(1'b1, `TIMER_REG_MTIMECMP_HI, '0, 4'hF, dummy);
		wb_access(1'b0, `TIMER_REG_MTIMECMP_LO, '0, 4'hF, val);
		expect_eq(val, t_lo + 32'd40, "mtimecmp low read back");
		waited	= 0;
		got		= 1'b0;
		irq_pc	= '0;
		while (!got && waited < IRQ_TIMEOUT) begin
			irq_pc = pc_now;
			retire_step(INST_NOP, '0, 1'b1);
			got = res.int_taken;
			waited++;
		end
		if (!got) begin
			$display("ERROR at time %0t: timer interrupt not taken within %0d instructions",
					 $time, IRQ_TIMEOUT);
			errors++;
		end else begin
			expect_eq(res.trap_addr, 32'h0000_0200 + 32'd28, "vectored timer entry");
			model[CSR_ADDR_MSTATUS] = trap_status(model[CSR_ADDR_MSTATUS]);
			csr_read(CSR_ADDR_MCAUSE, val);
			expect_eq(val, 32'h8000_0007, "timer mcause");
			csr_read(CSR_ADDR_MEPC, val);
			expect_eq(val, irq_pc, "timer mepc");
			csr_verify(CSR_ADDR_MSTATUS);
		end
		wb_access(1'b1, `TIMER_REG_MTIMECMP_HI, 32'hFFFF_FFFF, 4'hF, dummy);	// Quiet again
		csr_exec(F3_RC, CSR_ADDR_MIE, 5'd1, 5'd0, 32'h0000_0080);
		report_test("timer_interrupt", errs0);
	endtask

	task automatic take_interrupt(input int idx);
		xlen_t irq_pc;
		xlen_t val;
		csr_exec(F3_RS, CSR_ADDR_MSTATUS, 5'd1, 5'd0, 32'h0000_0008);	// Re-enable MIE
		irq_pc = pc_now;
		retire_step(INST_NOP, '0, 1'b1);
		expect_eq(32'(res.int_taken), 32'd1, $sformatf("int_taken for cause %0d", idx));
		expect_eq(res.trap_addr, {model[CSR_ADDR_MTVEC][31:2], 2'b00} + (32'(idx) << 2),
				  $sformatf("vector entry for cause %0d", idx));
		model[CSR_ADDR_MSTATUS] = trap_status(model[CSR_ADDR_MSTATUS]);
		csr_read(CSR_ADDR_MCAUSE, val);
		expect_eq(val, 32'h8000_0000 | 32'(idx), "priority mcause");
		csr_read(CSR_ADDR_MEPC, val);
		expect_eq(val, irq_pc, "priority mepc");
	endtask

	task automatic interrupt_priority_order();
		int		errs0;
		xlen_t	dummy;
		errs0 = errors;
		csr_exec(F3_RS, CSR_ADDR_MIE, 5'd1, 5'd0, 32'h0010_0808);	// Custom 4, MEIE, MSIE
		csr_verify(CSR_ADDR_MIE);
		wb_access(1'b1, `TIMER_REG_MSIP, 32'd1, 4'b0001, dummy);
		meip		= 1'b1;
		ext_irq[4]	= 1'b1;
		take_interrupt(20);
		ext_irq[4]	= 1'b0;
		take_interrupt(11);
		meip		= 1'b0;
		take_interrupt(3);
		wb_access(1'b1, `TIMER_REG_MSIP, 32'd0, 4'b0001, dummy);
		csr_verify(CSR_ADDR_MSTATUS);
		report_test("interrupt_priority", errs0);
	endtask

	initial begin
		int a;
		seed		= 32'haefd_a6ad;
		errors		= 0;
		checks		= 0;
		tests		= 0;
		reset		= 1'b1;
		ready		= 1'b1;
		retire_in	= '0;
		ext_irq		= '0;
		meip		= 1'b0;
		wb_req		= '0;
		pc_now		= 32'h0000_1000;
		for (a = 0; a < 4096; a++)
			model[a] = '0;
		model[CSR_ADDR_MISA]	= 32'h4000_1120;	// MXL 1, I, M, F
		model[CSR_ADDR_MSTATUS]	= 32'h0000_3800;	// MPP 3, FS 1
		repeat (2) @(posedge clk);
		#2;
		reset = 1'b0;
		check_reset_values();
		exercise_csr_ops();
		provoke_illegal_access();
		ecall_mret_sequence();
		timer_interrupt_flow();
		interrupt_priority_order();
		$display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: design/csr_subsys.sv
`default_nettype none

module csr_subsys (
	input	logic					clk,
	input	logic					reset,
	input	cpu_pkg::retire_in_t	retire,
	input	logic					ready,			// Low stalls the retire port
	input	logic	[15:0]			ext_irq,		// Custom lines, already synchronous
	input	logic					meip,
	input	bus_pkg::wb_req_t		wb_req,
	output	bus_pkg::wb_rsp_t		wb_rsp,
	output	cpu_pkg::retire_out_t	result,
	output	logic					m_ena,
	output	logic					f_ena,
	output	logic	[2:0]			fpu_rm
);

	import cpu_pkg::*;

	csr_req_t		req;
	xlen_t			int_pending;
	logic	[4:0]	int_cause;
	logic			timer_irq;
	logic			soft_irq;

	csr_decode u_decode (
		.retire	(retire),
		.req	(req)
	);

	csr_file u_csr_file (
		.clk			(clk),
		.reset			(reset),
		.retire			(retire),
		.ready			(ready),
		.req			(req),
		.int_cause		(int_cause),
		.int_pending	(int_pending),
		.int_req_ext	(ext_irq),
		.int_req_ictrl	(meip),
		.int_req_timer	(timer_irq),
		.int_req_soft	(soft_irq),
		.m_ena			(m_ena),
		.f_ena			(f_ena),
		.fpu_rm			(fpu_rm),
		.result			(result)
	);

	priority_encoder #(
		.IDX_W	(5)
	) u_int_enc (
		.x	(int_pending),
		.y	(int_cause)
	);

	machine_timer u_timer (
		.clk		(clk),
		.reset		(reset),
		.wb_req		(wb_req),
		.wb_rsp		(wb_rsp),
		.timer_irq	(timer_irq),
		.soft_irq	(soft_irq)
	);

endmodule

`default_nettype wire

// File: design/csr/csr_file.sv
`default_nettype none

`include "csr_cfg.svh"

module csr_file (
	input	logic					clk,
	input	logic					reset,
	input	cpu_pkg::retire_in_t	retire,
	input	logic					ready,
	input	cpu_pkg::csr_req_t		req,
	input	logic	[4:0]			int_cause,		// Highest pending enabled line
	output	cpu_pkg::xlen_t			int_pending,	// mip & mie
	input	logic	[15:0]			int_req_ext,
	input	logic					int_req_ictrl,
	input	logic					int_req_timer,
	input	logic					int_req_soft,
	output	logic					m_ena,
	output	logic					f_ena,
	output	logic	[2:0]			fpu_rm,
	output	cpu_pkg::retire_out_t	result
);

	import cpu_pkg::*;

	localparam xlen_t MTVEC_RESET = `CSR_MTVEC_RESET;

	logic	[1:0]	fs;				// FPU state, off/initial/clean/dirty
	logic			st_mpie;
	logic			st_mie;
	logic	[29:0]	tvec_base;
	logic			tvec_vect;		// Vectored interrupts
	logic	[15:0]	ie_custom;
	logic			ie_meie;
	logic			ie_mtie;
	logic			ie_msie;
	logic	[63:0]	mcycle;
	logic	[63:0]	minstret;
	logic			inh_ir;
	logic			inh_cy;
	xlen_t			mscratch;
	xlen_t			mepc;
	cause_t			mcause;
	xlen_t			mtval;
	logic	[4:0]	fflags;
	logic	[2:0]	frm;

	xlen_t			misa;
	xlen_t			mstatus;
	xlen_t			mtvec;
	xlen_t			mip;
	xlen_t			mie;
	xlen_t			rdata;
	xlen_t			wdata_rmw;		// Value after set/clear
	cause_t			trap_cause;
	logic			illegal_csr;
	logic			illegal_inst;
	logic			commit;			// Instruction takes effect

	// MXL 1, I always, M and F switchable
	assign misa		= {2'b01, 17'd0, m_ena, 3'd0, 1'b1, 2'd0, f_ena, 5'd0};
	assign mstatus	= {&fs, 16'd0, fs, 2'b11, 3'd0, st_mpie, 3'd0, st_mie, 3'd0};
	assign mtvec	= {tvec_base, 1'b0, tvec_vect};
	assign mip		= {int_req_ext, 4'd0, int_req_ictrl, 3'd0, int_req_timer, 3'd0,
					   int_req_soft, 3'd0};
	assign mie		= {ie_custom, 4'd0, ie_meie, 3'd0, ie_mtie, 3'd0, ie_msie, 3'd0};

	assign int_pending	= mip & mie;	// Fed to the encoder
	assign fpu_rm		= frm;

	always_comb begin
		rdata		= '0;
		illegal_csr	= 1'b0;
		case (req.addr)
		CSR_ADDR_MISA:			rdata = misa;
		CSR_ADDR_MVENDORID,
		CSR_ADDR_MARCHID,
		CSR_ADDR_MIMPID,
		CSR_ADDR_MHARTID,
		CSR_ADDR_MCONFIGPTR,
		CSR_ADDR_MSTATUSH:		rdata = '0;	// Hardwired zero
		CSR_ADDR_MSTATUS:		rdata = mstatus;
		CSR_ADDR_MTVEC:			rdata = mtvec;
		CSR_ADDR_MIP:			rdata = mip;
		CSR_ADDR_MIE:			rdata = mie;
		CSR_ADDR_MCYCLE:		rdata = mcycle[31:0];
		CSR_ADDR_MCYCLEH:		rdata = mcycle[63:32];
		CSR_ADDR_MINSTRET:		rdata = minstret[31:0];
		CSR_ADDR_MINSTRETH:		rdata = minstret[63:32];
		CSR_ADDR_MCOUNTINHIBIT:	rdata = {29'd0, inh_ir, 1'b0, inh_cy};
		CSR_ADDR_MSCRATCH:		rdata = mscratch;
		CSR_ADDR_MEPC:			rdata = mepc;
		CSR_ADDR_MCAUSE:		rdata = mcause;
		CSR_ADDR_MTVAL:			rdata = mtval;
		CSR_ADDR_FFLAGS:		begin
			rdata		= {27'd0, fflags};
			illegal_csr	= !f_ena;		// F registers gone with F off
		end
		CSR_ADDR_FRM:			begin
			rdata		= {29'd0, frm};
			illegal_csr	= !f_ena;
		end
		CSR_ADDR_FCSR:			begin
			rdata		= {24'd0, frm, fflags};
			illegal_csr	= !f_ena;
		end
		default:				illegal_csr = 1'b1;	// Unmapped
		endcase
	end

	always_comb begin
		case (req.op)
		CSR_RS:		wdata_rmw = rdata | req.wdata;
		CSR_RC:		wdata_rmw = rdata & ~req.wdata;
		default:	wdata_rmw = req.wdata;
		endcase
	end

	// Top two address bits set mark the read-only range
	assign illegal_inst = (req.wena && &req.addr[11:10]) ||
						  ((req.wena || req.rena) && illegal_csr);

	// Exception, then illegal access, then interrupt
	always_comb begin
		result		= '0;
		trap_cause	= '0;
		if (retire.valid && req.exc_pend) begin
			result.exc_taken	= 1'b1;
			trap_cause			= req.exc_cause;
		end else if (retire.valid && illegal_inst) begin
			result.exc_taken	= 1'b1;
			trap_cause			= CAUSE_ILLEGAL_INST;
		end else if (retire.valid && st_mie && |int_pending) begin
			result.int_taken	= 1'b1;			// Replaces this instruction
			trap_cause			= CAUSE_INTERRUPT | {27'd0, int_cause};
		end
		result.trap_taken	= result.exc_taken || result.int_taken;
		result.trap_addr	= {tvec_base, 2'b00};
		if (result.int_taken && tvec_vect)
			result.trap_addr = {tvec_base, 2'b00} + {25'd0, int_cause, 2'b00};
		result.rd_we		= req.rena && retire.valid && !result.trap_taken;
		result.rd_wdata		= rdata;
		result.ret_addr		= mepc;
	end

	assign commit = ready && retire.valid && !result.trap_taken;

	always_ff @(posedge clk) begin
		if (reset) begin
			m_ena		<= 1'b1;
			f_ena		<= 1'b1;
			fs			<= 2'd1;			// Initial
			st_mpie		<= 1'b0;
			st_mie		<= 1'b0;
			tvec_base	<= MTVEC_RESET[31:2];
			tvec_vect	<= MTVEC_RESET[0];
			ie_custom	<= '0;
			ie_meie		<= 1'b0;
			ie_mtie		<= 1'b0;
			ie_msie		<= 1'b0;
			mcycle		<= '0;
			minstret	<= '0;
			inh_ir		<= 1'b1;			// Counters start inhibited
			inh_cy		<= 1'b1;
			mscratch	<= '0;
			mepc		<= '0;
			mcause		<= '0;
			mtval		<= '0;
			fflags		<= '0;
			frm			<= '0;
		end else begin
			if (!inh_cy)
				mcycle <= mcycle + 64'd1;
			if (ready && result.trap_taken) begin
				st_mpie	<= st_mie;			// Stack enable, mask further traps
				st_mie	<= 1'b0;
				mepc	<= retire.pc;
				mcause	<= trap_cause;
			end
			if (commit) begin
				if (!inh_ir)
					minstret <= minstret + 64'd1;
				if (f_ena && retire.fpu_dirty) begin
					fflags	<= fflags | retire.fpu_flags;	// Sticky
					fs		<= 2'd3;
				end
				if (req.trap_ret) begin
					st_mie	<= st_mpie;
					st_mpie	<= 1'b1;
				end
				if (req.wena) begin
					case (req.addr)
					CSR_ADDR_MISA:			begin
						m_ena	<= wdata_rmw[12];
						f_ena	<= wdata_rmw[5];
						fs		<= {1'b0, wdata_rmw[5]};	// F off clears FS
					end
					CSR_ADDR_MSTATUS:		begin
						fs		<= f_ena ? wdata_rmw[14:13] : 2'd0;
						st_mpie	<= wdata_rmw[7];
						st_mie	<= wdata_rmw[3];
					end
					CSR_ADDR_MTVEC:			begin
						tvec_base	<= wdata_rmw[31:2];
						tvec_vect	<= wdata_rmw[1:0] == 2'd1;	// Other modes fall back to direct
					end
					CSR_ADDR_MIE:			begin
						ie_custom	<= wdata_rmw[31:16];
						ie_meie		<= wdata_rmw[11];
						ie_mtie		<= wdata_rmw[7];
						ie_msie		<= wdata_rmw[3];
					end
					CSR_ADDR_MCYCLE:		mcycle[31:0]	<= wdata_rmw;
					CSR_ADDR_MCYCLEH:		mcycle[63:32]	<= wdata_rmw;
					CSR_ADDR_MINSTRET:		minstret[31:0]	<= wdata_rmw;
					CSR_ADDR_MINSTRETH:		minstret[63:32]	<= wdata_rmw;
					CSR_ADDR_MCOUNTINHIBIT:	begin
						inh_ir	<= wdata_rmw[2];
						inh_cy	<= wdata_rmw[0];
					end
					CSR_ADDR_MSCRATCH:		mscratch	<= wdata_rmw;
					CSR_ADDR_MEPC:			mepc		<= {wdata_rmw[31:2], 2'b00};
					CSR_ADDR_MCAUSE:		mcause		<= wdata_rmw;
					CSR_ADDR_MTVAL:			mtval		<= wdata_rmw;
					CSR_ADDR_FFLAGS:		begin
						fflags	<= wdata_rmw[4:0];
						fs		<= 2'd3;			// Dirty
					end
					CSR_ADDR_FRM:			begin
						frm		<= wdata_rmw[2:0];
						fs		<= 2'd3;
					end
					CSR_ADDR_FCSR:			begin
						frm		<= wdata_rmw[7:5];
						fflags	<= wdata_rmw[4:0];
						fs		<= 2'd3;
					end
					default:				;	// Read-only or hardwired
					endcase
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: design/csr/csr_decode.sv
`default_nettype none

module csr_decode (
	input	cpu_pkg::retire_in_t	retire,
	output	cpu_pkg::csr_req_t		req
);

	import cpu_pkg::*;

	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	logic	[6:0]	opcode;
	logic	[4:0]	rd;
	logic	[2:0]	funct3;
	logic	[4:0]	rs1;			// Register index or zimm
	logic	[11:0]	funct12;		// CSR address or SYSTEM function
	xlen_t			src;

	assign opcode	= retire.inst[6:0];
	assign rd		= retire.inst[11:7];
	assign funct3	= retire.inst[14:12];
	assign rs1		= retire.inst[19:15];
	assign funct12	= retire.inst[31:20];

	assign src = funct3[2] ? {27'd0, rs1} : retire.rs1_val;	// Immediate forms

	always_comb begin
		req		= '0;
		req.op	= CSR_RW;
		if (opcode == OPC_SYSTEM) begin
			case (funct3)
			3'd0:		begin
				case (funct12)
				12'h000:	begin
					req.exc_pend	= 1'b1;			// ECALL
					req.exc_cause	= CAUSE_ECALL_M;
				end
				12'h001:	begin
					req.exc_pend	= 1'b1;			// EBREAK
					req.exc_cause	= CAUSE_BREAKPOINT;
				end
				12'h302:	req.trap_ret = 1'b1;	// MRET
				default:	begin
					req.exc_pend	= 1'b1;
					req.exc_cause	= CAUSE_ILLEGAL_INST;
				end
				endcase
			end
			3'd4:		begin
				req.exc_pend	= 1'b1;				// Reserved funct3
				req.exc_cause	= CAUSE_ILLEGAL_INST;
			end
			default:	begin
				req.op		= csr_op_t'(funct3[1:0]);
				req.addr	= funct12;
				req.wdata	= src;
				if (funct3[1:0] == 2'd1) begin
					req.wena	= 1'b1;
					req.rena	= rd != 5'd0;		// No side-effect read for x0
				end else begin
					req.rena	= 1'b1;
					req.wena	= rs1 != 5'd0;		// Pure read with zero source
				end
			end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/machine_timer.sv
`default_nettype none

`include "csr_cfg.svh"

module machine_timer (
	input	logic				clk,
	input	logic				reset,
	input	bus_pkg::wb_req_t	wb_req,
	output	bus_pkg::wb_rsp_t	wb_rsp,
	output	logic				timer_irq,
	output	logic				soft_irq
);

	import bus_pkg::*;

	logic	[63:0]	mtime;
	logic	[63:0]	mtimecmp;
	logic			msip;
	logic			ack;
	logic	[31:0]	rdata;			// Registered read data
	logic	[31:0]	rd_mux;
	logic			access;			// New bus cycle this clock
	logic			wr;
	wb_addr_t		adr;

	function automatic logic [31:0] merge(input logic [31:0] old_val,
										  input logic [31:0] new_val,
										  input logic [3:0] sel);
		logic [31:0] res;
		for (int b = 0; b < 4; b++)
			res[b*8 +: 8] = sel[b] ? new_val[b*8 +: 8] : old_val[b*8 +: 8];
		return res;
	endfunction

	assign access	= wb_req.cyc && wb_req.stb && !ack;	// Gap cycle after each ack
	assign wr		= access && wb_req.we;
	assign adr		= wb_req.adr;

	always_comb begin
		case (adr)
		`TIMER_REG_MSIP:		rd_mux = {31'd0, msip};
		`TIMER_REG_MTIMECMP_LO:	rd_mux = mtimecmp[31:0];
		`TIMER_REG_MTIMECMP_HI:	rd_mux = mtimecmp[63:32];
		`TIMER_REG_MTIME_LO:	rd_mux = mtime[31:0];
		`TIMER_REG_MTIME_HI:	rd_mux = mtime[63:32];
		default:				rd_mux = '0;		// Unmapped
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ack			<= 1'b0;
			mtime		<= '0;
			mtimecmp	<= '1;						// Quiet until programmed
			msip		<= 1'b0;
			timer_irq	<= 1'b0;
		end else begin
			ack			<= access;
			timer_irq	<= mtime >= mtimecmp;		// One cycle behind the compare
			mtime		<= mtime + 64'd1;
			if (wr) begin
				case (adr)
				`TIMER_REG_MSIP:		if (wb_req.sel[0]) msip <= wb_req.dat[0];
				`TIMER_REG_MTIMECMP_LO:	mtimecmp[31:0]	<= merge(mtimecmp[31:0], wb_req.dat, wb_req.sel);
				`TIMER_REG_MTIMECMP_HI:	mtimecmp[63:32]	<= merge(mtimecmp[63:32], wb_req.dat, wb_req.sel);
				`TIMER_REG_MTIME_LO:	mtime			<= {mtime[63:32], merge(mtime[31:0], wb_req.dat, wb_req.sel)};
				`TIMER_REG_MTIME_HI:	mtime			<= {merge(mtime[63:32], wb_req.dat, wb_req.sel), mtime[31:0]};
				default:				;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (access)
			rdata <= rd_mux;						// Old value on a write cycle
	end

	assign wb_rsp	= '{ack: ack, dat: rdata};
	assign soft_irq	= msip;

endmodule

`default_nettype wire

// File: design/priority_encoder.sv
`default_nettype none

module priority_encoder #(
	parameter int IDX_W = 5
) (
	input	logic	[2**IDX_W-1:0]	x,
	output	logic	[IDX_W-1:0]		y		// Highest set bit, 0 if none
);

	always_comb begin
		y = '0;
		for (int i = 0; i < 2**IDX_W; i++) begin
			if (x[i])
				y = IDX_W'(i);				// Later bits override
		end
	end

endmodule

`default_nettype wire

// File: common/bus_pkg.sv
`default_nettype none

package bus_pkg;

	typedef logic [3:0] wb_addr_t;	// Word address

	typedef struct packed {
		logic			cyc;
		logic			stb;
		logic			we;
		wb_addr_t		adr;
		logic	[31:0]	dat;	// Write data
		logic	[3:0]	sel;	// Byte lanes
	} wb_req_t;

	typedef struct packed {
		logic			ack;	// Single-cycle pulse
		logic	[31:0]	dat;	// Read data, valid with ack
	} wb_rsp_t;

endpackage

`default_nettype wire

// File: common/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	typedef logic [31:0] xlen_t;		// Machine word
	typedef logic [11:0] csr_addr_t;	// CSR address space
	typedef logic [31:0] cause_t;		// mcause encoding

	typedef enum logic [1:0] {
		CSR_RW = 2'd1,					// Matches funct3[1:0]
		CSR_RS = 2'd2,
		CSR_RC = 2'd3
	} csr_op_t;

	localparam csr_addr_t CSR_ADDR_FFLAGS		= 12'h001;
	localparam csr_addr_t CSR_ADDR_FRM			= 12'h002;
	localparam csr_addr_t CSR_ADDR_FCSR			= 12'h003;
	localparam csr_addr_t CSR_ADDR_MSTATUS		= 12'h300;
	localparam csr_addr_t CSR_ADDR_MISA			= 12'h301;
	localparam csr_addr_t CSR_ADDR_MIE			= 12'h304;
	localparam csr_addr_t CSR_ADDR_MTVEC		= 12'h305;
	localparam csr_addr_t CSR_ADDR_MSTATUSH		= 12'h310;
	localparam csr_addr_t CSR_ADDR_MCOUNTINHIBIT	= 12'h320;
	localparam csr_addr_t CSR_ADDR_MSCRATCH		= 12'h340;
	localparam csr_addr_t CSR_ADDR_MEPC			= 12'h341;
	localparam csr_addr_t CSR_ADDR_MCAUSE		= 12'h342;
	localparam csr_addr_t CSR_ADDR_MTVAL		= 12'h343;
	localparam csr_addr_t CSR_ADDR_MIP			= 12'h344;
	localparam csr_addr_t CSR_ADDR_MCYCLE		= 12'hB00;
	localparam csr_addr_t CSR_ADDR_MINSTRET		= 12'hB02;
	localparam csr_addr_t CSR_ADDR_MCYCLEH		= 12'hB80;
	localparam csr_addr_t CSR_ADDR_MINSTRETH	= 12'hB82;
	localparam csr_addr_t CSR_ADDR_MVENDORID	= 12'hF11;	// Read-only ID block
	localparam csr_addr_t CSR_ADDR_MARCHID		= 12'hF12;
	localparam csr_addr_t CSR_ADDR_MIMPID		= 12'hF13;
	localparam csr_addr_t CSR_ADDR_MHARTID		= 12'hF14;
	localparam csr_addr_t CSR_ADDR_MCONFIGPTR	= 12'hF15;

	localparam cause_t CAUSE_ILLEGAL_INST	= 32'd2;
	localparam cause_t CAUSE_BREAKPOINT		= 32'd3;
	localparam cause_t CAUSE_ECALL_M		= 32'd11;
	localparam cause_t CAUSE_INTERRUPT		= 32'h8000_0000;	// MSB flags interrupts

	typedef struct packed {
		logic			valid;		// Instruction retires this cycle
		xlen_t			inst;		// Raw encoding
		xlen_t			pc;
		xlen_t			rs1_val;	// Register source operand
		logic			fpu_dirty;	// FPU wrote its state
		logic	[4:0]	fpu_flags;	// Accrued exception flags
	} retire_in_t;

	typedef struct packed {
		csr_op_t		op;
		csr_addr_t		addr;
		logic			wena;
		logic			rena;
		xlen_t			wdata;		// rs1 value or zimm
		logic			trap_ret;	// MRET
		logic			exc_pend;	// ECALL, EBREAK or bad encoding
		cause_t			exc_cause;
	} csr_req_t;

	typedef struct packed {
		logic			rd_we;
		xlen_t			rd_wdata;	// Old CSR value
		logic			trap_taken;
		logic			exc_taken;
		logic			int_taken;
		xlen_t			trap_addr;	// Handler entry
		xlen_t			ret_addr;	// Current mepc
	} retire_out_t;

endpackage

`default_nettype wire

// File: common/csr_cfg.svh
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

// Timer register word addresses
`define TIMER_REG_MSIP			4'd0
`define TIMER_REG_MTIMECMP_LO	4'd1
`define TIMER_REG_MTIMECMP_HI	4'd2
`define TIMER_REG_MTIME_LO		4'd3
`define TIMER_REG_MTIME_HI		4'd4

// Trap vector after reset
`define CSR_MTVEC_RESET			32'h0000_0000

`endif
